// ==== common/agusec_defs.svh ====
`ifndef AGUSEC_DEFS_SVH
`define AGUSEC_DEFS_SVH

// ##########################################################
// capability pointer layout
// ##########################################################

// 44-bit address in the low bits
`define ptr_addr 43:0
// exponent, selects where the bounds window sits
`define ptr_exp 48:44
`define ptr_low 55:49 // low bound, widened with a 0
`define ptr_hi 62:56  // high bound, widened with a 1
// bit 63 unused

// ##########################################################
// buffering between producer and checker
// ##########################################################

`define AGUSEC_FIFO_DEPTH 4

`endif

// ==== common/agusec_pkg.sv ====
package agusec_pkg;

  // ##########################################################
  // widths with a meaning
  // ##########################################################

  typedef logic [63:0] ptr_t;   // compressed capability pointer
  typedef logic [43:0] addr_t;
  typedef logic [39:0] off_t;
  typedef logic [4:0]  exp_t;
  typedef logic [6:0]  bound_t;
  typedef logic [7:0]  win_t;   // address slice compared to bounds

  // ##########################################################
  // transfer structs
  // ##########################################################

  // one request on the input handshake
  typedef struct packed {
    ptr_t ptr;
    off_t a;
    off_t b;
  } agusec_req_t;

  // fifo entry, old pointer kept for the upper-bits check
  typedef struct packed {
    ptr_t  ptr;
    addr_t new_addr;
  } agusec_entry_t;

  typedef struct packed {
    addr_t new_addr;
    logic  window_ok;
    logic  upper_ok;
  } agusec_result_t;

  // ##########################################################
  // fsm states
  // ##########################################################

  typedef enum logic {gen_idle, gen_wait_drop} gen_state_t;

  typedef enum logic [1:0] {chk_idle, chk_hold, chk_wait_drop} chk_state_t;

endpackage

// ==== logic/agusec_fifo.sv ====
`timescale 1ns/100ps
`include "agusec_defs.svh"

module agusec_fifo (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      push,
  input  agusec_pkg::agusec_entry_t push_data,
  output logic                      full,
  input  logic                      pop,
  output agusec_pkg::agusec_entry_t pop_data,
  output logic                      empty
);

  localparam int depth = `AGUSEC_FIFO_DEPTH;
  localparam int ptr_w = $clog2(depth);

  typedef logic [ptr_w-1:0] fifo_ptr_t;
  typedef logic [ptr_w:0]   fifo_cnt_t;

  localparam fifo_ptr_t ptr_last = fifo_ptr_t'(depth - 1);
  localparam fifo_cnt_t cnt_max  = fifo_cnt_t'(depth);

  agusec_pkg::agusec_entry_t mem [depth];
  fifo_ptr_t                 wr_ptr;
  fifo_ptr_t                 rd_ptr;
  fifo_cnt_t                 count;
  logic                      do_push;
  logic                      do_pop;

  assign full  = (count == cnt_max);
  assign empty = (count == '0);

  assign do_push = push && !full;  // push on full is dropped
  assign do_pop  = pop && !empty;

  assign pop_data = mem[rd_ptr]; // head, no output register

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== agu/agusec_addr_gen.sv ====
`timescale 1ns/100ps

module agusec_addr_gen (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_req,
  input  agusec_pkg::agusec_req_t   in_data,
  output logic                      in_ack,
  input  logic                      full,
  output logic                      push,
  output agusec_pkg::agusec_entry_t push_data
);

  agusec_pkg::gen_state_t state;
  agusec_pkg::gen_state_t state_nxt;
  agusec_pkg::addr_t      base_addr;
  agusec_pkg::addr_t      off_a;
  agusec_pkg::addr_t      off_b;
  agusec_pkg::addr_t      sum_addr;

  // ##########################################################
  // address arithmetic
  // ##########################################################

  assign base_addr = agusec_pkg::addr_t'(in_data.ptr); // address field only
  assign off_a     = {4'b0000, in_data.a};
  assign off_b     = {4'b0000, in_data.b};

  // wraps at 2^44, carry out dropped
  assign sum_addr = base_addr + off_a + off_b;

  assign push_data.ptr      = in_data.ptr;
  assign push_data.new_addr = sum_addr;

  // ##########################################################
  // input four-phase handshake
  // ##########################################################

  // accept only when the fifo has room, else the request waits
  assign push = (state == agusec_pkg::gen_idle) && in_req && !full;

  assign in_ack = (state == agusec_pkg::gen_wait_drop); // up the cycle after push

  always_comb begin
    state_nxt = state;
    case (state)
      agusec_pkg::gen_idle: begin
        if (push) begin
          state_nxt = agusec_pkg::gen_wait_drop;
        end
      end
      agusec_pkg::gen_wait_drop: begin
        // requester has seen ack and released req
        if (!in_req) begin
          state_nxt = agusec_pkg::gen_idle;
        end
      end
      default: state_nxt = agusec_pkg::gen_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= agusec_pkg::gen_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== check/agusec_range.sv ====
`timescale 1ns/100ps
`include "agusec_defs.svh"

module agusec_range (
  input  agusec_pkg::ptr_t  ptr,
  input  agusec_pkg::addr_t new_addr,
  output logic              window_ok,
  output logic              upper_ok
);

  agusec_pkg::exp_t   exp;
  agusec_pkg::bound_t low_bound;
  agusec_pkg::bound_t hi_bound;
  agusec_pkg::addr_t  old_addr;
  agusec_pkg::addr_t  shifted;
  agusec_pkg::addr_t  upper_mask;
  agusec_pkg::win_t   bits;
  agusec_pkg::win_t   low_edge;
  agusec_pkg::win_t   high_edge;
  logic [5:0]         win_sh;
  logic [5:0]         upper_sh;

  assign exp       = ptr[`ptr_exp];
  assign low_bound = ptr[`ptr_low];
  assign hi_bound  = ptr[`ptr_hi];
  assign old_addr  = ptr[`ptr_addr];

  // ##########################################################
  // window at the exponent
  // ##########################################################

  // 4+31 needs six bits
  assign win_sh = {1'b0, exp} + 6'd4;

  assign shifted = new_addr >> win_sh;
  assign bits    = shifted[7:0];  // new_addr[11+e:4+e]

  // ##########################################################
  // bound compares
  // ##########################################################

  assign low_edge  = {low_bound, 1'b0};
  assign high_edge = {hi_bound, 1'b1};

  // no wrap case, low edge is taken as below high edge
  assign window_ok = (bits >= low_edge) && (bits <= high_edge);

  // ##########################################################
  // bits above the window
  // ##########################################################

  assign upper_sh = {1'b0, exp} + 6'd12; // at most 43

  // ones from 12+e up to 43
  assign upper_mask = {44{1'b1}} << upper_sh;

  // a carry out of the window shows up here
  assign upper_ok = ((old_addr ^ new_addr) & upper_mask) == '0;

endmodule

// ==== check/agusec_checker.sv ====
`timescale 1ns/100ps

module agusec_checker (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       empty,
  input  agusec_pkg::agusec_entry_t  pop_data,
  output logic                       pop,
  output logic                       res_req,
  output agusec_pkg::agusec_result_t res_data,
  input  logic                       res_ack
);

  agusec_pkg::chk_state_t state;
  agusec_pkg::chk_state_t state_nxt;
  logic                   win_ok;
  logic                   up_ok;

  // ##########################################################
  // bounds check on the fifo head
  // ##########################################################

  agusec_range u_range (
    .ptr       (pop_data.ptr),
    .new_addr  (pop_data.new_addr),
    .window_ok (win_ok),
    .upper_ok  (up_ok)
  );

  // one entry in flight at a time
  assign pop = (state == agusec_pkg::chk_idle) && !empty;

  // result captured with the pop
  always_ff @(posedge clk) begin
    if (pop) begin
      res_data.new_addr  <= pop_data.new_addr;
      res_data.window_ok <= win_ok;
      res_data.upper_ok  <= up_ok;
    end
  end

  // ##########################################################
  // output four-phase handshake
  // ##########################################################

  assign res_req = (state == agusec_pkg::chk_hold);

  always_comb begin
    state_nxt = state;
    case (state)
      agusec_pkg::chk_idle: begin
        if (pop) begin
          state_nxt = agusec_pkg::chk_hold;
        end
      end
      agusec_pkg::chk_hold: begin
        if (res_ack) begin
          state_nxt = agusec_pkg::chk_wait_drop; // drops req
        end
      end
      agusec_pkg::chk_wait_drop: begin
        // next pop only once ack is back low
        if (!res_ack) begin
          state_nxt = agusec_pkg::chk_idle;
        end
      end
      default: state_nxt = agusec_pkg::chk_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= agusec_pkg::chk_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== agusec_top.sv ====
`timescale 1ns/100ps

module agusec_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       in_req,
  input  agusec_pkg::agusec_req_t    in_data,
  output logic                       in_ack,
  output logic                       res_req,
  output agusec_pkg::agusec_result_t res_data,
  input  logic                       res_ack
);

  logic                      push;
  logic                      full;
  logic                      pop;
  logic                      empty;
  agusec_pkg::agusec_entry_t push_data;
  agusec_pkg::agusec_entry_t pop_data;

  // address add, producer side
  agusec_addr_gen u_addr_gen (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  agusec_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty)
  );

  agusec_checker u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .empty    (empty),
    .pop_data (pop_data),
    .pop      (pop),
    .res_req  (res_req),
    .res_data (res_data),
    .res_ack  (res_ack)
  );

endmodule

// ==== dv/tb_agusec.sv ====
`timescale 1ns/100ps
`include "agusec_defs.svh"

module tb_agusec;

  localparam int num_reqs    = 15 + 8 + 40;
  localparam int cycle_limit = num_reqs * 30 + 100; // worst case of 30 cycles per request
  localparam agusec_pkg::addr_t upper_pattern = 44'h5A5_A5A5_A5A5;

  logic                       clk;
  logic                       arst_n;
  logic                       in_req;
  agusec_pkg::agusec_req_t    in_data;
  logic                       in_ack;
  logic                       res_req;
  agusec_pkg::agusec_result_t res_data;
  logic                       res_ack;

  agusec_pkg::agusec_result_t exp_q[$];  // expected results in request order
  string                      name_q[$];
  logic [63:0]                rng_state = 64'd75501;
  logic                       stall_mode = 1'b0;
  logic                       res_req_q = 1'b0;
  int                         value_errs = 0;
  int                         flow_errs = 0;
  int                         sent = 0;
  int                         delivered = 0;
  int                         max_wait = 0;

  agusec_top dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .res_req  (res_req),
    .res_data (res_data),
    .res_ack  (res_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ##########################################################
  // helpers
  // ##########################################################

  function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic agusec_pkg::ptr_t make_ptr(input int e, input int low, input int hi,
                                                input agusec_pkg::addr_t addr);
    agusec_pkg::ptr_t p;
    p            = '0;
    p[`ptr_addr] = addr;
    p[`ptr_exp]  = agusec_pkg::exp_t'(e);
    p[`ptr_low]  = agusec_pkg::bound_t'(low);
    p[`ptr_hi]   = agusec_pkg::bound_t'(hi);
    return p;
  endfunction

  // reference model built bit by bit from the bounds rules
  function automatic agusec_pkg::agusec_result_t model_result(input agusec_pkg::agusec_req_t req);
    agusec_pkg::agusec_result_t r;
    agusec_pkg::addr_t          old_addr;
    agusec_pkg::win_t           win;
    logic [44:0]                sum;
    int                         base;
    old_addr   = req.ptr[`ptr_addr];
    sum        = {1'b0, old_addr} + {5'd0, req.a} + {5'd0, req.b};
    r.new_addr = sum[43:0];  // mod 2^44
    base       = 4 + int'(req.ptr[`ptr_exp]);
    for (int k = 0; k < 8; k++) begin
      win[k] = r.new_addr[base + k];
    end
    r.window_ok = (win >= {req.ptr[`ptr_low], 1'b0}) && (win <= {req.ptr[`ptr_hi], 1'b1});
    r.upper_ok  = 1'b1;
    for (int i = base + 8; i < 44; i++) begin
      if (r.new_addr[i] != old_addr[i]) begin
        r.upper_ok = 1'b0;
      end
    end
    return r;
  endfunction

  // four-phase request entered and left 1 ns after an edge
  task automatic send_req(input string name, input agusec_pkg::agusec_req_t req);
    agusec_pkg::agusec_result_t expd;
    int                         waited;
    expd    = model_result(req);
    waited  = 0;
    in_data = req;
    in_req  = 1'b1;
    @(posedge clk);
    #1;
    while (!in_ack) begin
      waited++;
      @(posedge clk);
      #1;
    end
    exp_q.push_back(expd);
    name_q.push_back(name);
    sent++;
    if (waited > max_wait) begin
      max_wait = waited;
    end
    in_req = 1'b0;
    while (in_ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  // moves the old window by step and names the flags it should give
  task automatic run_case(input string name, input int e, input int low, input int hi,
                          input int old_win, input int step, input logic want_win,
                          input logic want_up);
    agusec_pkg::agusec_req_t    req;
    agusec_pkg::agusec_result_t expd;
    agusec_pkg::addr_t          old_addr;
    old_addr = (upper_pattern & ({44{1'b1}} << (12 + e))) |
               (agusec_pkg::addr_t'(old_win) << (4 + e));
    req.ptr  = make_ptr(e, low, hi, old_addr);
    req.a    = agusec_pkg::off_t'(step) << (4 + e);
    req.b    = 40'h3; // below the window so no carry
    expd     = model_result(req);
    assert (expd.window_ok == want_win && expd.upper_ok == want_up) else begin
      value_errs++;
      $display("MISMATCH %s intended flags expected %b%b actual %b%b", name, want_win,
               want_up, expd.window_ok, expd.upper_ok);
    end
    send_req(name, req);
  endtask

  task automatic report_and_finish();
    $display("summary: %0d sent, %0d delivered, %0d value errors, %0d flow errors",
             sent, delivered, value_errs, flow_errs);
    if (value_errs == 0 && flow_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ##########################################################
  // result side
  // ##########################################################

  initial begin
    res_ack = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (res_req) begin
        repeat (stall_mode ? 15 : int'(next_rand() % 64'd9)) begin
          @(posedge clk);
          #1;
        end
        res_ack = 1'b1;
        while (res_req) begin
          @(posedge clk);
          #1;
        end
        res_ack = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n && res_req && !res_req_q) begin
      if (exp_q.size() == 0) begin
        flow_errs++;
        $display("result delivered with no request outstanding");
      end else begin
        delivered++;
        assert (res_data === exp_q[0]) else begin
          value_errs++;
          $display("MISMATCH %s expected %h actual %h", name_q[0], exp_q[0], res_data);
        end
        exp_q.delete(0);
        name_q.delete(0);
      end
    end
    // only fifo entries count here
    assert (sent - delivered <= 4) else begin
      flow_errs++;
      $display("more than four accepted requests waiting in the fifo");
    end
    res_req_q = res_req;
  end

  // ##########################################################
  // four-phase rules
  // ##########################################################

  in_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(in_ack) |-> $past(in_req))
    else begin
      flow_errs++;
      $display("in_ack rose without in_req");
    end
  in_req_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(in_req) |-> in_ack)
    else begin
      flow_errs++;
      $display("in_req dropped before in_ack");
    end
  in_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(in_ack) |-> !$past(in_req))
    else begin
      flow_errs++;
      $display("in_ack dropped while in_req still high");
    end
  in_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (in_req && $past(in_req)) |-> $stable(in_data))
    else begin
      flow_errs++;
      $display("in_data changed while in_req high");
    end
  res_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(res_ack) |-> res_req)
    else begin
      flow_errs++;
      $display("res_ack rose without res_req");
    end
  res_req_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(res_req) |-> $past(res_ack))
    else begin
      flow_errs++;
      $display("res_req dropped before res_ack");
    end
  res_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(res_ack) |-> !res_req)
    else begin
      flow_errs++;
      $display("res_ack dropped while res_req still high");
    end
  res_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (res_req && $past(res_req)) |-> $stable(res_data))
    else begin
      flow_errs++;
      $display("res_data changed while res_req high");
    end

  initial begin
    repeat (cycle_limit) @(posedge clk);
    flow_errs++;
    $display("run did not finish within %0d cycles", cycle_limit);
    report_and_finish();
  end

  // ##########################################################
  // stimulus
  // ##########################################################

  initial begin
    agusec_pkg::agusec_req_t req;
    logic [63:0]             r2;
    logic [63:0]             r3;
    arst_n  = 1'b0;
    in_req  = 1'b0;
    in_data = '0;
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      #1;
      assert (!in_ack && !res_req) else begin
        flow_errs++;
        $display("handshake outputs high around reset");
      end
      if (c == 2) begin
        arst_n = 1'b1;
      end
    end

    run_case("pass_low_edge", 0, 7'h10, 7'h30, 8'h10, 8'h10, 1'b1, 1'b1);
    run_case("pass_high_edge", 0, 7'h10, 7'h30, 8'h50, 8'h11, 1'b1, 1'b1);
    run_case("pass_mid", 15, 7'h08, 7'h40, 8'h20, 8'h20, 1'b1, 1'b1);
    run_case("pass_low_edge", 31, 7'h02, 7'h7E, 8'h04, 0, 1'b1, 1'b1);
    run_case("pass_high_edge", 31, 7'h02, 7'h7E, 8'hE0, 8'h1D, 1'b1, 1'b1);
    run_case("pass_full_range", 5, 7'h00, 7'h7F, 8'h00, 8'h1F, 1'b1, 1'b1);
    run_case("below_low", 0, 7'h10, 7'h30, 8'h10, 8'h0F, 1'b0, 1'b1);
    run_case("above_high", 0, 7'h10, 7'h30, 8'h50, 8'h12, 1'b0, 1'b1);
    run_case("below_low", 15, 7'h08, 7'h40, 8'h0F, 0, 1'b0, 1'b1);
    run_case("above_high", 15, 7'h08, 7'h40, 8'h80, 8'h02, 1'b0, 1'b1);
    run_case("below_low", 31, 7'h02, 7'h7E, 8'h01, 8'h02, 1'b0, 1'b1);
    run_case("above_high", 31, 7'h02, 7'h7E, 8'hF0, 8'h0E, 1'b0, 1'b1);
    run_case("carry_out", 0, 7'h00, 7'h7F, 8'hF0, 8'h14, 1'b1, 1'b0);
    run_case("carry_out", 15, 7'h08, 7'h40, 8'hFF, 8'h01, 1'b0, 1'b0);
    run_case("carry_out", 31, 7'h00, 7'h7F, 8'hFE, 8'h03, 1'b1, 1'b0);

    // slow acks pile entries up behind the checker
    stall_mode = 1'b1;
    max_wait   = 0;
    for (int i = 0; i < 8; i++) begin
      run_case("backpressure", 7, 7'h00, 7'h7F, i * 8, 3, 1'b1, 1'b1);
    end
    assert (max_wait >= 3) else begin
      flow_errs++;
      $display("input never stalled while results were held");
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    stall_mode = 1'b0;

    for (int i = 0; i < 40; i++) begin
      req.ptr = next_rand();
      r2      = next_rand();
      r3      = next_rand();
      req.a   = r2[39:0] >> r2[45:40]; // mix of small and large offsets
      req.b   = r3[39:0] >> r3[45:40];
      send_req("random", req);
    end

    while (exp_q.size() != 0 || res_req) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);
    assert (delivered == sent && sent == num_reqs) else begin
      flow_errs++;
      $display("result count does not match request count");
    end
    report_and_finish();
  end

endmodule

// ==== project.f ====
+incdir+common
common/agusec_pkg.sv
logic/agusec_fifo.sv
agu/agusec_addr_gen.sv
check/agusec_range.sv
check/agusec_checker.sv
agusec_top.sv
dv/tb_agusec.sv

// ==== Makefile ====
# Verilator flow for the bounds-check AGU

TOP := tb_agusec

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir
